/* flist.f */
+incdir+.
db_pkg.sv
db_store_array.sv
db_ctrl_engine.sv
db_stats.sv
db_top.sv
tb_db_top.sv

/* Bender.yml */
package:
  name: db_kv

sources:
  - include_dirs:
      - .
    files:
      - db_pkg.sv
      - db_store_array.sv
      - db_ctrl_engine.sv
      - db_stats.sv
      - db_top.sv

  - target: simulation
    include_dirs:
      - .
    files:
      - tb_db_top.sv

/* tb_db_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "db_defs.svh"

module tb_db_top
    import db_pkg::*;
();

    // ==================================================================
    // Run limits and signals
    // ==================================================================

    // Roughly 400 cycles of tests plus margin
    localparam int CYCLE_LIMIT = 2000;
    // Bound on any single wait for rdy, ack or init_done
    localparam int WAIT_LIMIT  = 64;
    // Accepting edge to ack for GET, SET and UNSET
    localparam int CMD_LAT     = 3;
    // Edge out of IDLE plus the sweep plus the edge of the registered level
    localparam int SWEEP_LAT   = `DB_DEPTH + 2;

    logic      clk;
    logic      arst_n;
    logic      req_valid;
    db_req_t   req;
    logic      init;
    logic      rdy;
    logic      ack;
    db_resp_t  resp;
    logic      init_done;
    db_stats_t stats;

    // Reference model with one record per slot plus the counters
    logic                     m_valid [`DB_DEPTH];
    logic [`DB_KEY_WID-1:0]   m_tag   [`DB_DEPTH];
    logic [`DB_VALUE_WID-1:0] m_value [`DB_DEPTH];
    int                       m_entries;
    int                       m_hits;
    int                       m_misses;

    logic [31:0]            rng_state;
    logic [`DB_KEY_WID-1:0] keys [6];
    int                     cycle_count = 0;
    int                     check_count = 0;
    int                     error_count = 0;

    db_top dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .rdy       (rdy),
        .ack       (ack),
        .resp      (resp),
        .init      (init),
        .init_done (init_done),
        .stats     (stats)
    );

    // 4 ns period
    always begin
        #2 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped, the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // ==================================================================
    // Helpers
    // ==================================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < `DB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        m_entries = 0;
    endtask

    task automatic check_stats();
        check_value(stats.entries, m_entries, "entry count");
        check_value(stats.hits, m_hits, "hit count");
        check_value(stats.misses, m_misses, "miss count");
    endtask

    // Model predicts the response and updates in place
    task automatic predict(input db_cmd_e cmd, input logic [`DB_KEY_WID-1:0] key,
                           input logic [`DB_VALUE_WID-1:0] value, output db_resp_t exp);
        logic [`DB_IDX_WID-1:0] slot;
        logic                   hit;
        slot       = key[`DB_IDX_WID-1:0];
        hit        = m_valid[slot] && (m_tag[slot] == key);
        exp        = '0;
        exp.status = DB_STATUS_OK;
        case (cmd)
            DB_CMD_GET: begin
                if (hit) begin
                    exp.found = 1'b1;
                    exp.value = m_value[slot];
                    m_hits++;
                end else begin
                    exp.status = DB_STATUS_MISS;
                    m_misses++;
                end
            end
            DB_CMD_SET: begin
                if (hit) begin
                    // Overwrite returns the old value
                    exp.found     = 1'b1;
                    exp.value     = m_value[slot];
                    m_value[slot] = value;
                end else if (m_valid[slot]) begin
                    exp.status = DB_STATUS_COLLISION;
                end else begin
                    m_valid[slot] = 1'b1;
                    m_tag[slot]   = key;
                    m_value[slot] = value;
                    m_entries++;
                end
            end
            DB_CMD_UNSET: begin
                if (hit) begin
                    exp.found     = 1'b1;
                    exp.value     = m_value[slot];
                    m_valid[slot] = 1'b0;
                    m_hits++;
                    m_entries--;
                end else begin
                    exp.status = DB_STATUS_MISS;
                    m_misses++;
                end
            end
            default: begin
                clear_model();
            end
        endcase
    endtask

    // Request held until ack before response, latency and counters are checked
    task automatic run_cmd(input db_cmd_e cmd, input logic [`DB_KEY_WID-1:0] key,
                           input logic [`DB_VALUE_WID-1:0] value);
        db_resp_t got;
        db_resp_t exp;
        logic     accepted;
        logic     got_ack;
        int       n;
        int       lat;
        req_valid <= 1'b1;
        req       <= '{cmd: cmd, key: key, value: value};
        accepted = 1'b0;
        got_ack  = 1'b0;
        got      = '0;
        n        = 0;
        lat      = 0;
        while (!accepted && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            check_value(ack, 1'b0, "ack before accept");
            accepted = rdy;
        end
        // Counted from the accepting edge
        while (accepted && !got_ack && lat < WAIT_LIMIT) begin
            @(posedge clk);
            lat++;
            if (ack) begin
                got_ack = 1'b1;
                got     = resp;
            end
        end
        req_valid <= 1'b0;
        if (!accepted) begin
            error_count++;
            $display("The DUT never raised rdy for a %s command", cmd.name());
        end else if (!got_ack) begin
            error_count++;
            $display("No ack from the DUT within %0d cycles of a %s command",
                     WAIT_LIMIT, cmd.name());
        end else begin
            predict(cmd, key, value, exp);
            check_value(got.status, exp.status, "status");
            check_value(got.found, exp.found, "found flag");
            check_value(got.value, exp.value, "value");
            check_value(lat, (cmd == DB_CMD_CLEAR) ? `DB_DEPTH + 1 : CMD_LAT, "ack latency");
        end
        // Counters move one cycle after the strobe
        @(posedge clk);
        check_stats();
    endtask

    // Wait for a full sweep with init dropped after its one-cycle pulse
    task automatic wait_sweep(input string what);
        logic seen_low;
        int   n;
        seen_low = 1'b0;
        n        = 0;
        while (!(seen_low && init_done) && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            init <= 1'b0;
            check_value(ack, 1'b0, "ack during sweep");
            check_value(rdy, init_done, "rdy against init_done");
            if (!init_done) begin
                seen_low = 1'b1;
            end
        end
        check_value(n, SWEEP_LAT, {"cycles to init_done after ", what});
    endtask

    // ==================================================================
    // Tests
    // ==================================================================

    task automatic test_power_up();
        logic [31:0] r;
        arst_n <= 1'b1;
        wait_sweep("reset");
        clear_model();
        check_stats();
        for (int i = 0; i < 4; i++) begin
            draw_rand(r);
            run_cmd(DB_CMD_GET, r[7:0], '0);
        end
    endtask

    task automatic test_set_get();
        logic [31:0] r;
        // One key per slot so no collisions here
        for (int i = 0; i < 6; i++) begin
            draw_rand(r);
            keys[i] = {r[7:4], 4'(i)};
            run_cmd(DB_CMD_SET, keys[i], r[31:16]);
        end
        for (int i = 0; i < 6; i++) begin
            run_cmd(DB_CMD_GET, keys[i], '0);
        end
        // Overwrites keep the entry count
        for (int i = 0; i < 3; i++) begin
            draw_rand(r);
            run_cmd(DB_CMD_SET, keys[i], r[15:0]);
            run_cmd(DB_CMD_GET, keys[i], '0);
        end
    endtask

    task automatic test_collision();
        logic [31:0] r;
        draw_rand(r);
        // Same slot with another key
        run_cmd(DB_CMD_SET, keys[0] ^ 8'h80, r[15:0]);
        run_cmd(DB_CMD_GET, keys[0], '0);
        run_cmd(DB_CMD_GET, keys[0] ^ 8'h80, '0);
    endtask

    task automatic test_unset();
        logic [31:0] r;
        run_cmd(DB_CMD_UNSET, keys[1], '0);
        run_cmd(DB_CMD_GET, keys[1], '0);
        run_cmd(DB_CMD_UNSET, keys[1], '0);
        // Freed slot takes a new key
        draw_rand(r);
        run_cmd(DB_CMD_SET, keys[1] ^ 8'h40, r[15:0]);
        run_cmd(DB_CMD_GET, keys[1] ^ 8'h40, '0);
    endtask

    task automatic test_clear();
        logic [31:0] r;
        run_cmd(DB_CMD_CLEAR, '0, '0);
        for (int i = 0; i < 6; i++) begin
            run_cmd(DB_CMD_GET, keys[i], '0);
        end
        for (int i = 0; i < 3; i++) begin
            draw_rand(r);
            run_cmd(DB_CMD_SET, keys[i], r[15:0]);
        end
        // Init pulse without an ack
        init <= 1'b1;
        wait_sweep("init");
        clear_model();
        @(posedge clk);
        check_stats();
        for (int i = 0; i < 3; i++) begin
            run_cmd(DB_CMD_GET, keys[i], '0);
        end
    endtask

    task automatic test_handshake();
        logic [31:0] r;
        db_cmd_e     cmd;
        // Small key space with two keys per slot
        for (int i = 0; i < 24; i++) begin
            draw_rand(r);
            cmd = db_cmd_e'(r[1:0]);
            if (cmd == DB_CMD_CLEAR) begin
                cmd = DB_CMD_GET;
            end
            run_cmd(cmd, {3'b000, r[8:4]}, r[31:16]);
        end
        // Held request must give a single ack
        run_cmd(DB_CMD_GET, 8'hf7, '0);
        repeat (6) begin
            @(posedge clk);
            check_value(ack, 1'b0, "ack after the held request");
            check_value(rdy, 1'b1, "rdy while idle");
        end
        check_stats();
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        init      = 1'b0;
        rng_state = 32'h97bc;
        m_hits    = 0;
        m_misses  = 0;
        clear_model();
        repeat (4) @(posedge clk);
        check_value(rdy, 1'b0, "rdy in reset");
        check_value(ack, 1'b0, "ack in reset");
        check_value(init_done, 1'b0, "init_done in reset");
        test_power_up();
        test_set_get();
        test_collision();
        test_unset();
        test_clear();
        test_handshake();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* db_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "db_defs.svh"

module db_top
    import db_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,

    // Host command port
    input  logic      req_valid,
    input  db_req_t   req,
    output logic      rdy,
    output logic      ack,
    output db_resp_t  resp,

    // Store init
    input  logic      init,
    output logic      init_done,

    // Statistics
    output db_stats_t stats
);

    // ================================================================
    // Internal wiring
    // ================================================================

    // Engine to store
    logic                   rd_en;
    logic [`DB_IDX_WID-1:0] rd_idx;
    db_entry_t              rd_entry;
    logic                   wr_en;
    logic [`DB_IDX_WID-1:0] wr_idx;
    db_entry_t              wr_entry;

    // Engine to statistics
    db_event_t              ev;

    // ================================================================
    // Instances
    // ================================================================

    // Command engine
    db_ctrl_engine u_ctrl_engine (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .init      (init),
        .rdy       (rdy),
        .ack       (ack),
        .init_done (init_done),
        .resp      (resp),
        .rd_en     (rd_en),
        .rd_idx    (rd_idx),
        .rd_entry  (rd_entry),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_entry  (wr_entry),
        .ev        (ev)
    );

    // Entry store
    db_store_array u_store_array (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_idx   (rd_idx),
        .rd_entry (rd_entry),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_entry (wr_entry)
    );

    // Statistics block
    db_stats u_stats (
        .clk    (clk),
        .arst_n (arst_n),
        .ev     (ev),
        .stats  (stats)
    );

endmodule

`default_nettype wire

/* db_stats.sv */
`timescale 1ns/100ps
`default_nettype none

module db_stats
    import db_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,

    // One-cycle strobes from the engine
    input  db_event_t ev,

    // Counter values, registered
    output db_stats_t stats
);

    // ================================================================
    // Counters
    // ================================================================

    db_stats_t stats_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stats_q <= '0;
        end else begin
            // Occupancy
            // Clear wins over any other strobe
            if (ev.clear) begin
                stats_q.entries <= '0;
            end else if (ev.insert && !ev.remove) begin
                stats_q.entries <= stats_q.entries + 1'b1;
            end else if (ev.remove && !ev.insert && (stats_q.entries != '0)) begin
                stats_q.entries <= stats_q.entries - 1'b1;
            end

            // Lookup hits, held at max
            if (ev.hit && (stats_q.hits != '1)) begin
                stats_q.hits <= stats_q.hits + 1'b1;
            end

            // Lookup misses, held at max
            if (ev.miss && (stats_q.misses != '1)) begin
                stats_q.misses <= stats_q.misses + 1'b1;
            end
        end
    end

    // Hit and miss counts survive a clear
    assign stats = stats_q;

endmodule

`default_nettype wire

/* db_ctrl_engine.sv */
`timescale 1ns/100ps
`default_nettype none

`include "db_defs.svh"

module db_ctrl_engine
    import db_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,

    // Host command port
    input  logic                   req_valid,
    input  db_req_t                req,
    input  logic                   init,
    output logic                   rdy,
    output logic                   ack,
    output logic                   init_done,
    output db_resp_t               resp,

    // Store read port
    output logic                   rd_en,
    output logic [`DB_IDX_WID-1:0] rd_idx,
    input  db_entry_t              rd_entry,

    // Store write port
    output logic                   wr_en,
    output logic [`DB_IDX_WID-1:0] wr_idx,
    output db_entry_t              wr_entry,

    // Statistics strobes
    output db_event_t              ev
);

    // ================================================================
    // Declarations
    // ================================================================

    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        READ,
        EVAL,
        RESP
    } state_e;

    // Index of the final sweep write
    localparam logic [`DB_IDX_WID-1:0] LAST_IDX = `DB_IDX_WID'(`DB_DEPTH - 1);

    state_e                 state_q;
    state_e                 state_d;
    logic [`DB_IDX_WID-1:0] sweep_cnt_q;
    logic                   sweep_last;
    logic                   init_done_q;
    logic                   clr_pend_q;
    logic                   accept;
    logic                   accept_clr;
    logic                   slot_hit;
    db_req_t                req_q;
    db_resp_t               resp_q;
    db_resp_t               eval_resp;
    db_entry_t              wr_entry_q;
    db_entry_t              eval_entry;
    logic                   wr_pend_q;
    logic                   eval_wr;
    db_event_t              ev_q;
    db_event_t              eval_ev;

    // Handshake
    assign rdy        = (state_q == IDLE) && init_done_q;
    assign accept     = req_valid && rdy;
    assign accept_clr = accept && (req.cmd == DB_CMD_CLEAR);

    // Final cycle of a sweep
    assign sweep_last = (state_q == SWEEP) && (sweep_cnt_q == LAST_IDX);

    // ================================================================
    // Next state
    // ================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept_clr) begin
                    state_d = SWEEP;
                end else if (accept) begin
                    state_d = READ;
                end else if (!init_done_q || init) begin
                    // Power-up or init pulse
                    state_d = SWEEP;
                end
            end
            SWEEP: begin
                if (sweep_last) begin
                    // Only a CLEAR command gets an ack
                    if (clr_pend_q) begin
                        state_d = RESP;
                    end else begin
                        state_d = IDLE;
                    end
                end
            end
            READ:    state_d = EVAL;
            EVAL:    state_d = RESP;
            RESP:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // ================================================================
    // Hit, miss and collision decode
    // ================================================================

    // Tag compare on the entry read back
    assign slot_hit = rd_entry.valid && (rd_entry.tag == req_q.key);

    always_comb begin
        eval_resp        = '0;
        eval_resp.status = DB_STATUS_OK;
        eval_wr          = 1'b0;
        eval_entry       = '0;
        eval_entry.tag   = req_q.key;
        eval_ev          = '0;
        case (req_q.cmd)
            DB_CMD_GET: begin
                if (slot_hit) begin
                    eval_resp.found = 1'b1;
                    eval_resp.value = rd_entry.value;
                    eval_ev.hit     = 1'b1;
                end else begin
                    eval_resp.status = DB_STATUS_MISS;
                    eval_ev.miss     = 1'b1;
                end
            end
            DB_CMD_SET: begin
                eval_entry.valid = 1'b1;
                eval_entry.value = req_q.value;
                if (slot_hit) begin
                    // Overwrite, old value returned
                    eval_resp.found = 1'b1;
                    eval_resp.value = rd_entry.value;
                    eval_wr         = 1'b1;
                end else if (rd_entry.valid) begin
                    // Slot owned by another key
                    eval_resp.status = DB_STATUS_COLLISION;
                end else begin
                    eval_wr        = 1'b1;
                    eval_ev.insert = 1'b1;
                end
            end
            DB_CMD_UNSET: begin
                if (slot_hit) begin
                    // Invalid entry written back
                    eval_resp.found = 1'b1;
                    eval_resp.value = rd_entry.value;
                    eval_wr         = 1'b1;
                    eval_ev.hit     = 1'b1;
                    eval_ev.remove  = 1'b1;
                end else begin
                    eval_resp.status = DB_STATUS_MISS;
                    eval_ev.miss     = 1'b1;
                end
            end
            default: begin
                // CLEAR never reaches EVAL
                eval_wr = 1'b0;
            end
        endcase
    end

    // ================================================================
    // Control registers
    // ================================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= IDLE;
            sweep_cnt_q <= '0;
            init_done_q <= 1'b0;
            clr_pend_q  <= 1'b0;
            wr_pend_q   <= 1'b0;
            ev_q        <= '0;
        end else begin
            state_q <= state_d;

            // Sweep counter, back to zero for the next sweep
            if (state_q == SWEEP) begin
                if (sweep_last) begin
                    sweep_cnt_q <= '0;
                end else begin
                    sweep_cnt_q <= sweep_cnt_q + 1'b1;
                end
            end

            // Low from CLEAR or init until the sweep ends
            if (state_q == SWEEP) begin
                if (sweep_last) begin
                    init_done_q <= 1'b1;
                end
            end else if (init || accept_clr) begin
                init_done_q <= 1'b0;
            end

            if (accept_clr) begin
                clr_pend_q <= 1'b1;
            end else if (sweep_last) begin
                clr_pend_q <= 1'b0;
            end

            // Write and strobes live for the RESP cycle only
            wr_pend_q <= (state_q == EVAL) && eval_wr;
            ev_q      <= (state_q == EVAL) ? eval_ev : '0;
            ev_q.clear <= sweep_last;
        end
    end

    // ================================================================
    // Payload registers
    // ================================================================

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (state_q == EVAL) begin
            resp_q     <= eval_resp;
            wr_entry_q <= eval_entry;
        end else if (sweep_last) begin
            resp_q <= '{status: DB_STATUS_OK, found: 1'b0, value: '0};
        end
    end

    // ================================================================
    // Outputs
    // ================================================================

    assign ack       = (state_q == RESP);
    assign resp      = resp_q;
    assign init_done = init_done_q;
    assign ev        = ev_q;

    // Low key bits select the slot
    assign rd_en  = (state_q == READ);
    assign rd_idx = req_q.key[`DB_IDX_WID-1:0];

    // Sweep writes invalid entries, RESP writes the RMW result
    always_comb begin
        if (state_q == SWEEP) begin
            wr_en    = 1'b1;
            wr_idx   = sweep_cnt_q;
            wr_entry = '0;
        end else begin
            wr_en    = wr_pend_q;
            wr_idx   = rd_idx;
            wr_entry = wr_entry_q;
        end
    end

endmodule

`default_nettype wire

/* db_store_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "db_defs.svh"

module db_store_array
    import db_pkg::*;
(
    input  logic                   clk,

    // Read port with data one cycle after rd_en
    input  logic                   rd_en,
    input  logic [`DB_IDX_WID-1:0] rd_idx,
    output db_entry_t              rd_entry,

    // Write port committed at the clock edge
    input  logic                   wr_en,
    input  logic [`DB_IDX_WID-1:0] wr_idx,
    input  db_entry_t              wr_entry
);

    // ================================================================
    // Storage
    // ================================================================

    // One entry per slot
    // Valid flag lives inside each entry
    db_entry_t mem [`DB_DEPTH];

    // Registered read data
    db_entry_t rd_q;

    // ================================================================
    // Write port
    // ================================================================

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_entry;
        end
    end

    // ================================================================
    // Read port
    // ================================================================

    // Read data held while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_q <= mem[rd_idx];
        end
    end

    // Straight from the read register
    assign rd_entry = rd_q;

endmodule

`default_nettype wire

/* db_pkg.sv */
`default_nettype none

`include "db_defs.svh"

package db_pkg;

    // ================================================================
    // Command port encodings
    // ================================================================

    // Host commands
    typedef enum logic [1:0] {
        DB_CMD_GET   = 2'd0,
        DB_CMD_SET   = 2'd1,
        DB_CMD_UNSET = 2'd2,
        DB_CMD_CLEAR = 2'd3
    } db_cmd_e;

    // Response status, OK is all zeros
    typedef enum logic [1:0] {
        DB_STATUS_OK        = 2'd0,
        DB_STATUS_MISS      = 2'd1,
        DB_STATUS_COLLISION = 2'd2
    } db_status_e;

    // Host request
    typedef struct packed {
        db_cmd_e                   cmd;
        logic [`DB_KEY_WID-1:0]    key;
        logic [`DB_VALUE_WID-1:0]  value;
    } db_req_t;

    // Engine response
    typedef struct packed {
        db_status_e                status;
        logic                      found;
        logic [`DB_VALUE_WID-1:0]  value;
    } db_resp_t;

    // ================================================================
    // Internal words
    // ================================================================

    // Store word, full key kept as tag
    typedef struct packed {
        logic                      valid;
        logic [`DB_KEY_WID-1:0]    tag;
        logic [`DB_VALUE_WID-1:0]  value;
    } db_entry_t;

    // One-cycle strobes from engine to statistics
    typedef struct packed {
        logic hit;
        logic miss;
        logic insert;
        logic remove;
        logic clear;
    } db_event_t;

    // Statistics counters
    typedef struct packed {
        logic [`DB_CNT_WID-1:0] entries;
        logic [`DB_CNT_WID-1:0] hits;
        logic [`DB_CNT_WID-1:0] misses;
    } db_stats_t;

endpackage

`default_nettype wire

/* db_defs.svh */
`ifndef DB_DEFS_SVH
`define DB_DEFS_SVH

// ====================================================================
// Key and value widths
// ====================================================================

// Full key width, also stored as the slot tag
`define DB_KEY_WID 8

// Value payload width
`define DB_VALUE_WID 16

// ====================================================================
// Store geometry
// ====================================================================

// Number of direct-mapped slots
`define DB_DEPTH 16

// Slot index width, low key bits
`define DB_IDX_WID 4

// ====================================================================
// Statistics
// ====================================================================

// Width of each statistics counter
`define DB_CNT_WID 16

`endif
